/* bench/dma_checker.sv */
// Protocol checks bound into every dma_top instance
// Assumes each ext_req_o is answered by exactly one ext_valid_i
`timescale 1ns/1ps

module dma_checker (
	input logic           clk,
	input logic           rst,
	input logic           e_op_o,
	input logic           ifm_we_o,
	input logic           ext_we_o,
	input logic           ext_req_o,
	input logic           ext_valid_i,
	input dma_pkg::addr_t ext_addr_o
);

	logic rd_open_q; // Request sent, valid not seen yet

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			rd_open_q <= 1'b0;
		else if (ext_valid_i)
			rd_open_q <= 1'b0; // Valid may come in the request cycle
		else if (ext_req_o)
			rd_open_q <= 1'b1;
	end

	done_pulse: assert property (@(posedge clk) disable iff (rst) e_op_o |=> !e_op_o)
		else $error("e_op_o held for more than one cycle");

	write_excl: assert property (@(posedge clk) disable iff (rst) !(ifm_we_o && ext_we_o))
		else $error("ifm_we_o and ext_we_o high in the same cycle");

	one_read: assert property (@(posedge clk) disable iff (rst) ext_req_o |-> !rd_open_q)
		else $error("second ext_req_o before ext_valid_i");

	// Address must not move until the word comes back
	addr_hold: assert property (@(posedge clk) disable iff (rst)
		(ext_req_o || rd_open_q) && !ext_valid_i |=> $stable(ext_addr_o))
		else $error("ext_addr_o changed while a read was open");

	// Read port and flush writes share ext_addr_o
	addr_mux_excl: assert property (@(posedge clk) disable iff (rst)
		ext_we_o |-> !(ext_req_o || rd_open_q))
		else $error("ext_we_o high while an external read was open");

endmodule

bind dma_top dma_checker u_checker (
	.clk(clk), .rst(rst), .e_op_o(e_op_o), .ifm_we_o(ifm_we_o), .ext_we_o(ext_we_o),
	.ext_req_o(ext_req_o), .ext_valid_i(ext_valid_i), .ext_addr_o(ext_addr_o)
);

/* bench/dma_tb.sv */
// Random descriptor, fill and flush runs against a loop model of the tile rules
// Memory answers after 0 to 5 cycles, output buffer has one cycle of read latency
`timescale 1ns/1ps

module dma_tb;

	localparam int TILE_X     = 6;
	localparam int TILE_Y     = 6;
	localparam int KERNEL     = 3;
	localparam int HALO       = KERNEL >> 1;
	localparam int OP_TIMEOUT = 5000; // Cycles per operation
	localparam int IDLE_WAIT  = 20;

	logic clk, rst, s_op_i, e_op_o;
	dma_pkg::op_e   op_i;
	dma_pkg::dim_t  tx_i, ty_i, nix_o, niy_o;
	dma_pkg::chan_t nif_o, nof_o;
	logic           stride_o, ext_req_o, ext_valid_i, ext_we_o, ifm_we_o, ofm_re_o;
	dma_pkg::word_t ext_rdata_i, ext_wdata_o, buf_wdata_o, ofm_rdata_i;
	dma_pkg::addr_t ext_addr_o, buf_addr_o;

	dma_pkg::word_t desc_mem [0:3];
	dma_pkg::word_t ofm_buf [0:255];
	dma_pkg::addr_t exp_req[$], exp_baddr[$], exp_eaddr[$], got_req[$], got_baddr[$], got_eaddr[$];
	dma_pkg::word_t exp_bdata[$], exp_edata[$], got_bdata[$], got_edata[$];
	int m_nix, m_niy, m_nif, m_nof, m_stride, m_ifm_base, m_ofm_base; // Model layer state
	int done_cnt = 0;
	int done_base, exp_done, test_errs, tests_run, tests_failed;
	int rd_cnt;              // Buffer read strobes in this test
	int wait_left;           // Memory response countdown
	dma_pkg::addr_t rd_addr_q;
	logic rd_pend;           // Buffer read issued last cycle
	dma_pkg::addr_t rd_pend_addr;
	string test_name;

	dma_top #(.TILE_X(TILE_X), .TILE_Y(TILE_Y), .KERNEL(KERNEL)) i_dut (
		.clk(clk), .rst(rst), .s_op_i(s_op_i), .op_i(op_i), .tx_i(tx_i), .ty_i(ty_i),
		.e_op_o(e_op_o), .ext_req_o(ext_req_o), .ext_valid_i(ext_valid_i),
		.ext_rdata_i(ext_rdata_i), .ext_addr_o(ext_addr_o), .ext_we_o(ext_we_o),
		.ext_wdata_o(ext_wdata_o), .ifm_we_o(ifm_we_o), .ofm_re_o(ofm_re_o),
		.buf_addr_o(buf_addr_o), .buf_wdata_o(buf_wdata_o), .ofm_rdata_i(ofm_rdata_i),
		.nix_o(nix_o), .niy_o(niy_o), .nif_o(nif_o), .nof_o(nof_o), .stride_o(stride_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Descriptor at 0 to 3, hashed word elsewhere
	function automatic dma_pkg::word_t ext_word(input dma_pkg::addr_t a);
		if (a < 32'(dma_pkg::DESC_WORDS))
			return desc_mem[a[1:0]];
		return (a * 32'h9E37_79B1) ^ {a[7:0], a[31:8]};
	endfunction

	// External memory, one answer per request
	initial begin
		ext_valid_i = 1'b0;
		ext_rdata_i = '0;
		wait_left   = -1;
		forever begin
			@(negedge clk);
			ext_valid_i = 1'b0;
			if (ext_req_o) begin
				rd_addr_q = ext_addr_o;
				wait_left = $urandom_range(5, 0); // 0 answers in the request cycle
			end
			if (wait_left == 0) begin
				ext_valid_i = 1'b1;
				ext_rdata_i = ext_word(rd_addr_q);
			end
			if (wait_left >= 0)
				wait_left--;
		end
	end

	// Output buffer, data one cycle after the read strobe
	initial begin
		ofm_rdata_i = '0;
		rd_pend     = 1'b0;
		forever begin
			@(negedge clk);
			if (rd_pend)
				ofm_rdata_i = ofm_buf[rd_pend_addr[7:0]];
			rd_pend      = ofm_re_o;
			rd_pend_addr = buf_addr_o;
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			if (ext_req_o)
				got_req.push_back(ext_addr_o);
			if (ifm_we_o) begin
				got_baddr.push_back(buf_addr_o);
				got_bdata.push_back(buf_wdata_o);
			end
			if (ext_we_o) begin
				got_eaddr.push_back(ext_addr_o);
				got_edata.push_back(ext_wdata_o);
			end
			if (ofm_re_o)
				rd_cnt++;
			if (e_op_o)
				done_cnt++;
		end
	end

	task automatic check_val(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
		assert (act_v === exp_v) else begin
			$display("ERR %s %s expected %h actual %h", test_name, what, exp_v, act_v);
			test_errs++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
		exp_done  = 1;
		done_base = done_cnt;
		rd_cnt    = 0;
		exp_req.delete();
		exp_baddr.delete();
		exp_bdata.delete();
		exp_eaddr.delete();
		exp_edata.delete();
		got_req.delete();
		got_baddr.delete();
		got_bdata.delete();
		got_eaddr.delete();
		got_edata.delete();
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s ok", test_name);
		end else begin
			$display("test %s failed with %0d errors", test_name, test_errs);
			tests_failed++;
		end
	endtask

	task automatic check_streams();
		int i;
		check_val("read count", exp_req.size(), got_req.size());
		for (i = 0; i < exp_req.size() && i < got_req.size(); i++)
			check_val("read addr", exp_req[i], got_req[i]);
		check_val("buffer write count", exp_baddr.size(), got_baddr.size());
		for (i = 0; i < exp_baddr.size() && i < got_baddr.size(); i++) begin
			check_val("buffer addr", exp_baddr[i], got_baddr[i]);
			check_val("buffer data", exp_bdata[i], got_bdata[i]);
		end
		check_val("buffer read count", exp_eaddr.size(), rd_cnt); // One read per flushed word
		check_val("ext write count", exp_eaddr.size(), got_eaddr.size());
		for (i = 0; i < exp_eaddr.size() && i < got_eaddr.size(); i++) begin
			check_val("ext write addr", exp_eaddr[i], got_eaddr[i]);
			check_val("ext write data", exp_edata[i], got_edata[i]);
		end
		check_val("e_op pulses", exp_done, done_cnt - done_base);
	endtask

	task automatic start_op(input dma_pkg::op_e op, input int tx, input int ty);
		@(negedge clk);
		s_op_i = 1'b1;
		op_i   = op;
		tx_i   = 8'(tx);
		ty_i   = 8'(ty);
		@(negedge clk);
		s_op_i = 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (!e_op_o && cycles < OP_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!e_op_o) begin
			$display("Timeout in %s, no e_op_o after %0d cycles", test_name, OP_TIMEOUT);
			test_errs++;
		end
		@(negedge clk); // Let the monitor take the last strobe
	endtask

	// Input tile rows stop at the tile edge or one halo past the map
	task automatic model_fill(input int tx0, input int ty0);
		int f, x, y, tx, ty, ea, ba;
		logic pad;
		for (f = 1; f <= m_nif; f++) begin
			for (y = 1; y <= TILE_Y; y++) begin
				ty = ty0 + y - 1;
				if (ty > m_niy + HALO)
					break;
				for (x = 1; x <= TILE_X; x++) begin
					tx = tx0 + x - 1;
					if (tx > m_nix + HALO)
						break;
					pad = (tx == 0) || (ty == 0) || (tx > m_nix) || (ty > m_niy);
					ea  = m_ifm_base + (f - 1) * m_nix * m_niy + (ty - 1) * m_nix + (tx - 1);
					ba  = (f - 1) * TILE_X * TILE_Y + (y - 1) * TILE_X + (x - 1);
					if (!pad)
						exp_req.push_back(32'(ea));
					exp_baddr.push_back(32'(ba));
					exp_bdata.push_back(pad ? 32'd0 : ext_word(32'(ea)));
				end
			end
		end
	endtask

	// Output tile is the input tile shifted by the stride, rows stop at nox
	task automatic model_flush(input int tx0, input int ty0);
		int f, x, y, tx, ty, ea, ba, tox, toy, nox, noy;
		tox = TILE_X >> m_stride;
		toy = TILE_Y >> m_stride;
		nox = m_nix >> m_stride;
		noy = m_niy >> m_stride;
		for (f = 1; f <= m_nof; f++) begin
			for (y = 1; y <= toy; y++) begin
				ty = ty0 + y - 1;
				if (ty > noy)
					break;
				for (x = 1; x <= tox; x++) begin
					tx = tx0 + x - 1;
					if (tx > nox)
						break;
					ea = m_ofm_base + (f - 1) * nox * noy + (ty - 1) * nox + (tx - 1);
					ba = (f - 1) * tox * toy + (y - 1) * tox + (x - 1);
					exp_eaddr.push_back(32'(ea));
					exp_edata.push_back(ofm_buf[ba]);
				end
			end
		end
	endtask

	task automatic load_desc(input string name, input int stride);
		begin_test(name);
		m_nix      = $urandom_range(12, 8);
		m_niy      = $urandom_range(12, 8);
		m_nif      = $urandom_range(3, 1);
		m_nof      = $urandom_range(3, 1);
		m_stride   = stride;
		m_ifm_base = $urandom_range(4000, 16); // Clear of the descriptor words
		m_ofm_base = $urandom_range(60000, 8000);
		desc_mem[0] = (32'(m_nix) << dma_pkg::DESC_NIX_LSB) | (32'(m_niy) << dma_pkg::DESC_NIY_LSB)
			| (32'(m_stride) << dma_pkg::DESC_STRIDE_BIT);
		desc_mem[1] = (32'(m_nif) << dma_pkg::DESC_NIF_LSB) | (32'(m_nof) << dma_pkg::DESC_NOF_LSB);
		desc_mem[2] = 32'(m_ifm_base);
		desc_mem[3] = 32'(m_ofm_base);
		exp_req = {32'd0, 32'd1, 32'd2, 32'd3};
		start_op(dma_pkg::OP_LOAD_DESC, 0, 0);
		wait_done();
		check_val("nix_o", 32'(m_nix), 32'(nix_o));
		check_val("niy_o", 32'(m_niy), 32'(niy_o));
		check_val("nif_o", 32'(m_nif), 32'(nif_o));
		check_val("nof_o", 32'(m_nof), 32'(nof_o));
		check_val("stride_o", 32'(m_stride), 32'(stride_o));
		check_streams();
		end_test();
	endtask

	task automatic fill_test(input string name, input logic corner);
		int tx, ty;
		begin_test(name);
		tx = corner ? 0 : $urandom_range(m_nix - TILE_X + 1, 1);
		ty = corner ? 0 : $urandom_range(m_niy - TILE_Y + 1, 1);
		model_fill(tx, ty);
		start_op(dma_pkg::OP_FILL_IFM, tx, ty);
		wait_done();
		check_streams();
		end_test();
	endtask

	task automatic flush_test(input string name);
		int tx, ty;
		begin_test(name);
		tx = $urandom_range(m_nix >> m_stride, 1);
		ty = $urandom_range(m_niy >> m_stride, 1);
		model_flush(tx, ty);
		start_op(dma_pkg::OP_FLUSH_OFM, tx, ty);
		wait_done();
		check_streams();
		end_test();
	endtask

	// Start while busy and a dropped opcode, neither may finish an operation
	task automatic ignore_test(input string name);
		int tx, ty, k;
		begin_test(name);
		tx = $urandom_range(m_nix - TILE_X + 1, 1);
		ty = $urandom_range(m_niy - TILE_Y + 1, 1);
		model_fill(tx, ty);
		start_op(dma_pkg::OP_FILL_IFM, tx, ty);
		repeat (3) @(negedge clk);
		s_op_i = 1'b1;
		op_i   = dma_pkg::OP_FLUSH_OFM;
		@(negedge clk);
		s_op_i = 1'b0;
		wait_done();
		start_op(dma_pkg::op_e'(3'd3), 0, 0); // Weight load, dropped
		for (k = 0; k < IDLE_WAIT; k++)
			@(negedge clk);
		check_streams();
		end_test();
	endtask

	initial begin
		int unsigned seed_val;
		int i;
		seed_val = $urandom(55645);
		rst    = 1'b1;
		s_op_i = 1'b0;
		op_i   = dma_pkg::OP_LOAD_DESC;
		tx_i   = '0;
		ty_i   = '0;
		tests_run    = 0;
		tests_failed = 0;
		for (i = 0; i < 256; i++)
			ofm_buf[i] = $urandom;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		load_desc("desc_load", int'($urandom_range(1, 0)));
		fill_test("fill_interior", 1'b0);
		fill_test("fill_corner", 1'b1);
		load_desc("desc_stride0", 0);
		flush_test("flush_stride0");
		load_desc("desc_stride1", 1);
		flush_test("flush_stride1");
		ignore_test("ignore_ops");

		$display("tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
			tests_failed);
		if (tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* list.f */
logic/dma_pkg.sv
logic/dma_if.sv
logic/ext_read_port.sv
logic/layer_regs.sv
logic/tile_addr_gen.sv
logic/dma_sequencer.sv
logic/out_port.sv
logic/dma_top.sv
bench/dma_checker.sv
bench/dma_tb.sv

/* logic/dma_if.sv */
// Read channel allows one request in flight, rd_start waits for rd_done
// Output command channel has no back-pressure, one command per cycle
`timescale 1ns/1ps

interface rd_if;
	logic           rd_start; // One-cycle start of a pixel or word read
	logic           rd_pad;   // Halo pixel, returns zero without a request
	dma_pkg::addr_t rd_addr;  // External word address
	logic           rd_done;  // rd_data valid in this cycle
	dma_pkg::word_t rd_data;

	modport seq (
		output rd_start, rd_pad, rd_addr,
		input  rd_done, rd_data
	);
	modport port (
		input  rd_start, rd_pad, rd_addr,
		output rd_done, rd_data
	);
endinterface

interface out_if;
	dma_pkg::cmd_e  cmd;          // CMD_NONE when idle
	dma_pkg::addr_t cmd_buf_addr; // Tile buffer address
	dma_pkg::addr_t cmd_ext_addr; // External address, flush only
	dma_pkg::word_t cmd_data;     // Pixel for an input buffer write

	modport seq (
		output cmd, cmd_buf_addr, cmd_ext_addr, cmd_data
	);
	modport port (
		input  cmd, cmd_buf_addr, cmd_ext_addr, cmd_data
	);
endinterface

/* logic/dma_pkg.sv */
// Four-word layer descriptor, fixed at external addresses 0 to 3
// Opcodes 2 to 4 and any other code outside op_e are treated as no-ops
package dma_pkg;

	typedef logic [31:0] addr_t; // External or buffer word address
	typedef logic [31:0] word_t; // Data word
	typedef logic [7:0]  dim_t;  // Spatial size or 1-based index
	typedef logic [10:0] chan_t; // Channel count or 1-based index

	// Operation codes kept from the accelerator command set
	typedef enum logic [2:0] {
		OP_LOAD_DESC = 3'd0,
		OP_FILL_IFM  = 3'd1,
		OP_FLUSH_OFM = 3'd5
	} op_e;

	// Commands from sequencer to the output pipeline
	typedef enum logic [1:0] {
		CMD_NONE      = 2'd0,
		CMD_IFM_WRITE = 2'd1, // Buffer write of one input pixel
		CMD_OFM_READ  = 2'd2  // Buffer read, then external write
	} cmd_e;

	localparam int DESC_WORDS = 4;

	// Word index inside the descriptor
	localparam logic [1:0] DESC_DIM_IDX  = 2'd0;
	localparam logic [1:0] DESC_CHAN_IDX = 2'd1;
	localparam logic [1:0] DESC_IFM_IDX  = 2'd2;
	localparam logic [1:0] DESC_OFM_IDX  = 2'd3;

	// Field positions in word 0
	localparam int DESC_NIX_LSB    = 0;
	localparam int DESC_NIY_LSB    = 8;
	localparam int DESC_STRIDE_BIT = 16;

	// Field positions in word 1
	localparam int DESC_NIF_LSB = 0;
	localparam int DESC_NOF_LSB = 12;

endpackage

/* logic/dma_sequencer.sv */
// One operation at a time, s_op_i only sampled in IDLE
// Fill waits on each read, flush issues one buffer read per cycle
`timescale 1ns/1ps

module dma_sequencer #(
	parameter int TILE_X = 6,
	parameter int TILE_Y = 6,
	parameter int KERNEL = 3
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           s_op_i,
	input  dma_pkg::op_e   op_i,
	input  dma_pkg::dim_t  tx_i,
	input  dma_pkg::dim_t  ty_i,
	output logic           e_op_o,
	rd_if.seq              rd,
	out_if.seq             oc,
	output logic           desc_we_o,
	output logic [1:0]     desc_idx_o,
	input  dma_pkg::chan_t nif_i,
	input  dma_pkg::chan_t nof_i,
	input  dma_pkg::dim_t  niy_i,
	input  dma_pkg::dim_t  nix_i,
	input  dma_pkg::dim_t  nox_i,
	input  dma_pkg::dim_t  noy_i,
	input  logic           stride_i,
	input  dma_pkg::addr_t ifm_base_i,
	input  dma_pkg::addr_t ofm_base_i,
	input  dma_pkg::addr_t ifm_chan_size_i,
	input  dma_pkg::addr_t ofm_chan_size_i
);

	localparam int HALO = KERNEL >> 1;

	typedef enum logic [2:0] {IDLE, DESC_RD, FILL_RD, FILL_WR, FLUSH, DRAIN, DONE} seq_state_e;

	seq_state_e     state_q;
	dma_pkg::op_e   mode_q;
	dma_pkg::dim_t  x_q, y_q, tx_q, ty_q; // Tile and map positions
	dma_pkg::dim_t  tx0_q, ty0_q;         // Tile origin in the map
	dma_pkg::chan_t f_q;
	logic [1:0]     idx_q;                // Descriptor word
	logic [1:0]     drain_q;
	logic           issue_q;              // Start pulse for the next read
	dma_pkg::word_t data_q;               // Pixel waiting for its buffer write

	logic           fill, row_end, col_end, last;
	dma_pkg::dim_t  tox, toy;
	dma_pkg::dim_t  x_nx, y_nx, tx_nx, ty_nx;
	dma_pkg::chan_t f_nx;
	logic           pad;
	dma_pkg::addr_t gen_ext_addr, gen_buf_addr;

	tile_addr_gen #(.TILE_X(TILE_X), .TILE_Y(TILE_Y)) u_addr (
		.mode_i(mode_q), .x_i(x_q), .y_i(y_q), .f_i(f_q), .tx_i(tx_q), .ty_i(ty_q),
		.nix_i(nix_i), .niy_i(niy_i), .nox_i(nox_i), .stride_i(stride_i),
		.ifm_base_i(ifm_base_i), .ofm_base_i(ofm_base_i),
		.ifm_chan_size_i(ifm_chan_size_i), .ofm_chan_size_i(ofm_chan_size_i),
		.pad_o(pad), .ext_addr_o(gen_ext_addr), .buf_addr_o(gen_buf_addr)
	);

	// Loop bounds and next counter values
	always_comb begin
		fill = (mode_q == dma_pkg::OP_FILL_IFM);
		tox  = dma_pkg::dim_t'(TILE_X) >> stride_i;
		toy  = dma_pkg::dim_t'(TILE_Y) >> stride_i;
		if (fill) begin // Stop at tile edge or past the halo
			row_end = (x_q == dma_pkg::dim_t'(TILE_X)) || (tx_q == nix_i + dma_pkg::dim_t'(HALO));
			col_end = (y_q == dma_pkg::dim_t'(TILE_Y)) || (ty_q == niy_i + dma_pkg::dim_t'(HALO));
			last    = row_end && col_end && (f_q == nif_i);
		end else begin
			row_end = (x_q == tox) || (tx_q == nox_i);
			col_end = (y_q == toy) || (ty_q == noy_i);
			last    = row_end && col_end && (f_q == nof_i);
		end

		x_nx  = x_q + 8'd1;
		tx_nx = tx_q + 8'd1;
		y_nx  = y_q;
		ty_nx = ty_q;
		f_nx  = f_q;
		if (row_end) begin // Back to the tile's first column
			x_nx  = 8'd1;
			tx_nx = tx0_q;
			y_nx  = y_q + 8'd1;
			ty_nx = ty_q + 8'd1;
			if (col_end) begin // Next channel plane
				y_nx  = 8'd1;
				ty_nx = ty0_q;
				f_nx  = f_q + 11'd1;
			end
		end
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state_q <= IDLE;
			mode_q  <= dma_pkg::OP_LOAD_DESC;
			x_q     <= '0;
			y_q     <= '0;
			tx_q    <= '0;
			ty_q    <= '0;
			tx0_q   <= '0;
			ty0_q   <= '0;
			f_q     <= '0;
			idx_q   <= '0;
			drain_q <= '0;
			issue_q <= 1'b0;
		end else begin
			issue_q <= 1'b0;
			case (state_q)
				IDLE: if (s_op_i) begin
					mode_q <= op_i;
					x_q    <= 8'd1;
					y_q    <= 8'd1;
					f_q    <= 11'd1;
					tx_q   <= tx_i;
					ty_q   <= ty_i;
					tx0_q  <= tx_i;
					ty0_q  <= ty_i;
					idx_q  <= '0;
					case (op_i)
						dma_pkg::OP_LOAD_DESC: begin
							state_q <= DESC_RD;
							issue_q <= 1'b1;
						end
						dma_pkg::OP_FILL_IFM: begin
							state_q <= FILL_RD;
							issue_q <= 1'b1;
						end
						dma_pkg::OP_FLUSH_OFM: state_q <= FLUSH;
						default: state_q <= IDLE; // Dropped opcodes
					endcase
				end
				DESC_RD: if (rd.rd_done) begin
					if (idx_q == 2'(dma_pkg::DESC_WORDS - 1)) begin
						state_q <= DONE;
					end else begin
						idx_q   <= idx_q + 2'd1;
						issue_q <= 1'b1;
					end
				end
				FILL_RD: if (rd.rd_done) state_q <= FILL_WR;
				FILL_WR: begin // Write command goes out this cycle
					x_q  <= x_nx;
					y_q  <= y_nx;
					tx_q <= tx_nx;
					ty_q <= ty_nx;
					f_q  <= f_nx;
					if (last) begin
						state_q <= DONE;
					end else begin
						state_q <= FILL_RD;
						issue_q <= 1'b1;
					end
				end
				FLUSH: begin
					x_q  <= x_nx;
					y_q  <= y_nx;
					tx_q <= tx_nx;
					ty_q <= ty_nx;
					f_q  <= f_nx;
					if (last) begin
						state_q <= DRAIN;
						drain_q <= '0;
					end
				end
				DRAIN: begin // Cover the three-stage out_port pipeline
					drain_q <= drain_q + 2'd1;
					if (drain_q == 2'd2)
						state_q <= DONE;
				end
				DONE:    state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == FILL_RD && rd.rd_done)
			data_q <= rd.rd_data;
	end

	assign rd.rd_start = issue_q;
	assign rd.rd_pad   = (state_q == FILL_RD) && pad;
	assign rd.rd_addr  = (state_q == DESC_RD) ? dma_pkg::addr_t'(idx_q) : gen_ext_addr;

	assign desc_we_o  = (state_q == DESC_RD) && rd.rd_done;
	assign desc_idx_o = idx_q;

	always_comb begin
		case (state_q)
			FILL_WR: oc.cmd = dma_pkg::CMD_IFM_WRITE;
			FLUSH:   oc.cmd = dma_pkg::CMD_OFM_READ;
			default: oc.cmd = dma_pkg::CMD_NONE;
		endcase
	end
	assign oc.cmd_buf_addr = gen_buf_addr;
	assign oc.cmd_ext_addr = gen_ext_addr;
	assign oc.cmd_data     = data_q;

	assign e_op_o = (state_q == DONE);

endmodule

/* logic/dma_top.sv */
// Tile DMA with plain strobes, no acknowledge on writes
// ext_addr_o is shared by reads and flush writes, which never overlap
`timescale 1ns/1ps

module dma_top #(
	parameter int TILE_X = 6, // Input tile width with halo
	parameter int TILE_Y = 6,
	parameter int KERNEL = 3
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           s_op_i,
	input  dma_pkg::op_e   op_i,
	input  dma_pkg::dim_t  tx_i,
	input  dma_pkg::dim_t  ty_i,
	output logic           e_op_o,
	output logic           ext_req_o,
	input  logic           ext_valid_i,
	input  dma_pkg::word_t ext_rdata_i,
	output dma_pkg::addr_t ext_addr_o,
	output logic           ext_we_o,
	output dma_pkg::word_t ext_wdata_o,
	output logic           ifm_we_o,
	output logic           ofm_re_o,
	output dma_pkg::addr_t buf_addr_o,
	output dma_pkg::word_t buf_wdata_o,
	input  dma_pkg::word_t ofm_rdata_i,
	output dma_pkg::dim_t  nix_o,
	output dma_pkg::dim_t  niy_o,
	output dma_pkg::chan_t nif_o,
	output dma_pkg::chan_t nof_o,
	output logic           stride_o
);

	rd_if  rd_bus ();
	out_if oc_bus ();

	dma_pkg::addr_t rp_ext_addr, op_ext_addr; // Read and write address sources
	logic           desc_we;
	logic [1:0]     desc_idx;
	dma_pkg::dim_t  nox, noy;
	dma_pkg::addr_t ifm_base, ofm_base, ifm_chan_size, ofm_chan_size;

	ext_read_port u_rd (
		.clk(clk), .rst(rst), .rd(rd_bus.port),
		.ext_req_o(ext_req_o), .ext_valid_i(ext_valid_i),
		.ext_rdata_i(ext_rdata_i), .ext_addr_o(rp_ext_addr)
	);

	// Descriptor words come straight off the read channel
	layer_regs u_regs (
		.clk(clk), .rst(rst), .desc_we_i(desc_we), .desc_idx_i(desc_idx),
		.desc_word_i(rd_bus.rd_data),
		.nix_o(nix_o), .niy_o(niy_o), .nif_o(nif_o), .nof_o(nof_o), .stride_o(stride_o),
		.nox_o(nox), .noy_o(noy), .ifm_base_o(ifm_base), .ofm_base_o(ofm_base),
		.ifm_chan_size_o(ifm_chan_size), .ofm_chan_size_o(ofm_chan_size)
	);

	dma_sequencer #(.TILE_X(TILE_X), .TILE_Y(TILE_Y), .KERNEL(KERNEL)) u_seq (
		.clk(clk), .rst(rst), .s_op_i(s_op_i), .op_i(op_i), .tx_i(tx_i), .ty_i(ty_i),
		.e_op_o(e_op_o), .rd(rd_bus.seq), .oc(oc_bus.seq),
		.desc_we_o(desc_we), .desc_idx_o(desc_idx),
		.nif_i(nif_o), .nof_i(nof_o), .niy_i(niy_o), .nix_i(nix_o),
		.nox_i(nox), .noy_i(noy), .stride_i(stride_o),
		.ifm_base_i(ifm_base), .ofm_base_i(ofm_base),
		.ifm_chan_size_i(ifm_chan_size), .ofm_chan_size_i(ofm_chan_size)
	);

	out_port u_out (
		.clk(clk), .rst(rst), .oc(oc_bus.port),
		.ifm_we_o(ifm_we_o), .ofm_re_o(ofm_re_o),
		.buf_addr_o(buf_addr_o), .buf_wdata_o(buf_wdata_o), .ofm_rdata_i(ofm_rdata_i),
		.ext_we_o(ext_we_o), .ext_addr_o(op_ext_addr), .ext_wdata_o(ext_wdata_o)
	);

	assign ext_addr_o = ext_we_o ? op_ext_addr : rp_ext_addr; // Write wins only while strobed

endmodule

/* logic/ext_read_port.sv */
// Single outstanding external read, ext_addr_o held until ext_valid_i
// Padded reads finish next cycle with zero data and never touch memory
`timescale 1ns/1ps

module ext_read_port (
	input  logic           clk,
	input  logic           rst,
	rd_if.port             rd,
	output logic           ext_req_o,
	input  logic           ext_valid_i,
	input  dma_pkg::word_t ext_rdata_i,
	output dma_pkg::addr_t ext_addr_o
);

	typedef enum logic {RP_IDLE, RP_WAIT} rp_state_e;

	rp_state_e      state_q;
	logic           req_q;  // Request pulse
	logic           done_q; // Completion pulse to sequencer
	dma_pkg::addr_t addr_q;
	dma_pkg::word_t data_q;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state_q <= RP_IDLE;
			req_q   <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			req_q  <= 1'b0; // Both strobes last one cycle
			done_q <= 1'b0;
			case (state_q)
				RP_IDLE: if (rd.rd_start) begin
					if (rd.rd_pad) begin
						done_q <= 1'b1; // Halo pixel, answer at once
					end else begin
						req_q   <= 1'b1;
						state_q <= RP_WAIT;
					end
				end
				RP_WAIT: if (ext_valid_i) begin // Valid may share the request cycle
					done_q  <= 1'b1;
					state_q <= RP_IDLE;
				end
				default: state_q <= RP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == RP_IDLE && rd.rd_start) begin
			data_q <= '0; // Zero for halo, overwritten on a real read
			if (!rd.rd_pad)
				addr_q <= rd.rd_addr; // Address stays put while waiting
		end else if (state_q == RP_WAIT && ext_valid_i) begin
			data_q <= ext_rdata_i;
		end
	end

	assign ext_req_o  = req_q;
	assign ext_addr_o = addr_q;
	assign rd.rd_done = done_q;
	assign rd.rd_data = data_q;

endmodule

/* logic/layer_regs.sv */
// Layer registers load one cycle after the descriptor word strobe
// Channel size products lag the dimensions by one more cycle
`timescale 1ns/1ps

module layer_regs (
	input  logic           clk,
	input  logic           rst,
	input  logic           desc_we_i,
	input  logic [1:0]     desc_idx_i,
	input  dma_pkg::word_t desc_word_i,
	output dma_pkg::dim_t  nix_o,
	output dma_pkg::dim_t  niy_o,
	output dma_pkg::chan_t nif_o,
	output dma_pkg::chan_t nof_o,
	output logic           stride_o,
	output dma_pkg::dim_t  nox_o,
	output dma_pkg::dim_t  noy_o,
	output dma_pkg::addr_t ifm_base_o,
	output dma_pkg::addr_t ofm_base_o,
	output dma_pkg::addr_t ifm_chan_size_o,
	output dma_pkg::addr_t ofm_chan_size_o
);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			nix_o      <= '0;
			niy_o      <= '0;
			stride_o   <= 1'b0;
			nif_o      <= '0;
			nof_o      <= '0;
			ifm_base_o <= '0;
			ofm_base_o <= '0;
		end else if (desc_we_i) begin
			case (desc_idx_i)
				dma_pkg::DESC_DIM_IDX: begin
					nix_o    <= desc_word_i[dma_pkg::DESC_NIX_LSB +: 8];
					niy_o    <= desc_word_i[dma_pkg::DESC_NIY_LSB +: 8];
					stride_o <= desc_word_i[dma_pkg::DESC_STRIDE_BIT];
				end
				dma_pkg::DESC_CHAN_IDX: begin
					nif_o <= desc_word_i[dma_pkg::DESC_NIF_LSB +: 11];
					nof_o <= desc_word_i[dma_pkg::DESC_NOF_LSB +: 11];
				end
				dma_pkg::DESC_IFM_IDX: ifm_base_o <= desc_word_i;
				dma_pkg::DESC_OFM_IDX: ofm_base_o <= desc_word_i;
				default: ;
			endcase
		end
	end

	// Stride 1 halves the output map
	assign nox_o = nix_o >> stride_o;
	assign noy_o = niy_o >> stride_o;

	// Words per channel plane, registered to keep multipliers off the address path
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			ifm_chan_size_o <= '0;
			ofm_chan_size_o <= '0;
		end else begin
			ifm_chan_size_o <= dma_pkg::addr_t'(nix_o) * dma_pkg::addr_t'(niy_o);
			ofm_chan_size_o <= dma_pkg::addr_t'(nox_o) * dma_pkg::addr_t'(noy_o);
		end
	end

endmodule

/* logic/out_port.sv */
// Output buffer assumed to have exactly one cycle of read latency
// Fill writes and flush reads share buf_addr_o, never in the same cycle
`timescale 1ns/1ps

module out_port (
	input  logic           clk,
	input  logic           rst,
	out_if.port            oc,
	output logic           ifm_we_o,
	output logic           ofm_re_o,
	output dma_pkg::addr_t buf_addr_o,
	output dma_pkg::word_t buf_wdata_o,
	input  dma_pkg::word_t ofm_rdata_i,
	output logic           ext_we_o,
	output dma_pkg::addr_t ext_addr_o,
	output dma_pkg::word_t ext_wdata_o
);

	logic           rd_pend_q;            // Buffer data arrives this cycle
	dma_pkg::addr_t ext_addr1_q, ext_addr2_q; // External address riding along

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			ifm_we_o  <= 1'b0;
			ofm_re_o  <= 1'b0;
			rd_pend_q <= 1'b0;
			ext_we_o  <= 1'b0;
		end else begin
			ifm_we_o  <= (oc.cmd == dma_pkg::CMD_IFM_WRITE); // Stage 1
			ofm_re_o  <= (oc.cmd == dma_pkg::CMD_OFM_READ);
			rd_pend_q <= ofm_re_o;                           // Stage 2
			ext_we_o  <= rd_pend_q;                          // Stage 3
		end
	end

	always_ff @(posedge clk) begin
		buf_addr_o  <= oc.cmd_buf_addr;
		buf_wdata_o <= oc.cmd_data;
		ext_addr1_q <= oc.cmd_ext_addr;
		ext_addr2_q <= ext_addr1_q;
		ext_addr_o  <= ext_addr2_q;
		ext_wdata_o <= ofm_rdata_i; // Capture read data with its address
	end

endmodule

/* logic/tile_addr_gen.sv */
// Pure address arithmetic, all counters 1-based, tx or ty of 0 is padding
// Flush tiles are TILE_X by TILE_Y shifted right by the stride
`timescale 1ns/1ps

module tile_addr_gen #(
	parameter int TILE_X = 6,
	parameter int TILE_Y = 6
) (
	input  dma_pkg::op_e   mode_i,
	input  dma_pkg::dim_t  x_i,
	input  dma_pkg::dim_t  y_i,
	input  dma_pkg::chan_t f_i,
	input  dma_pkg::dim_t  tx_i,
	input  dma_pkg::dim_t  ty_i,
	input  dma_pkg::dim_t  nix_i,
	input  dma_pkg::dim_t  niy_i,
	input  dma_pkg::dim_t  nox_i,
	input  logic           stride_i,
	input  dma_pkg::addr_t ifm_base_i,
	input  dma_pkg::addr_t ofm_base_i,
	input  dma_pkg::addr_t ifm_chan_size_i,
	input  dma_pkg::addr_t ofm_chan_size_i,
	output logic           pad_o,
	output dma_pkg::addr_t ext_addr_o,
	output dma_pkg::addr_t buf_addr_o
);

	logic           fill;
	dma_pkg::addr_t tile_w, tile_h; // Buffer tile size for this mode
	dma_pkg::addr_t row_len;        // Map row length in external memory
	dma_pkg::addr_t f_off, x_off, y_off, tx_off, ty_off; // Zero-based offsets

	always_comb begin
		fill = (mode_i == dma_pkg::OP_FILL_IFM);
		if (fill) begin
			tile_w  = dma_pkg::addr_t'(TILE_X);
			tile_h  = dma_pkg::addr_t'(TILE_Y);
			row_len = dma_pkg::addr_t'(nix_i);
		end else begin
			tile_w  = dma_pkg::addr_t'(TILE_X) >> stride_i;
			tile_h  = dma_pkg::addr_t'(TILE_Y) >> stride_i;
			row_len = dma_pkg::addr_t'(nox_i);
		end

		f_off  = dma_pkg::addr_t'(f_i) - 32'd1;
		x_off  = dma_pkg::addr_t'(x_i) - 32'd1;
		y_off  = dma_pkg::addr_t'(y_i) - 32'd1;
		tx_off = dma_pkg::addr_t'(tx_i) - 32'd1; // Garbage on halo, unused then
		ty_off = dma_pkg::addr_t'(ty_i) - 32'd1;

		// Channel planes packed back to back in the buffer
		buf_addr_o = f_off * tile_w * tile_h + y_off * tile_w + x_off;

		if (fill)
			ext_addr_o = ifm_base_i + f_off * ifm_chan_size_i + ty_off * row_len + tx_off;
		else
			ext_addr_o = ofm_base_i + f_off * ofm_chan_size_i + ty_off * row_len + tx_off;

		// Outside the map on any side, fill only
		pad_o = fill && (tx_i == '0 || ty_i == '0 || tx_i > nix_i || ty_i > niy_i);
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the tile DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module dma_tb -f list.f

# A stopped or failing run leaves the pass line out
out=$(./obj_dir/Vdma_tb) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
echo "simulation did not pass" >&2
exit 1
